// File: cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic widths
  //////////////////////////////////////////////////////////////////////

  // data, address and instruction word
  typedef logic [31:0] word_t;
  // register file index
  typedef logic [4:0] reg_idx_t;
  // alu function code, same encoding as r-type func
  typedef logic [5:0] func_t;

  //////////////////////////////////////////////////////////////////////
  // opcodes, instruction [31:26]
  //////////////////////////////////////////////////////////////////////

  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQZ  = 6'h04;
  localparam logic [5:0] OP_BNEZ  = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_JR    = 6'h12;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  //////////////////////////////////////////////////////////////////////
  // r-type func field, instruction [5:0]
  //////////////////////////////////////////////////////////////////////

  localparam func_t FN_ADD = 6'h20;
  localparam func_t FN_SUB = 6'h22;
  localparam func_t FN_AND = 6'h24;
  localparam func_t FN_OR  = 6'h25;
  localparam func_t FN_XOR = 6'h26;
  localparam func_t FN_SLT = 6'h2a;

  // jal writes its return address here
  localparam reg_idx_t LINK_REG = 5'd31;

  // first fetch address out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // all zero word, r-type into r0, harmless in any slot
  localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

// File: inst_fetch.sv
`timescale 1ns/10ps

module inst_fetch (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,
  input  logic           branch,
  input  logic           jmp,
  input  logic           jmp_r,
  input  logic [15:0]    imm16,
  input  logic [25:0]    jmp_imm26,
  input  cpu_pkg::word_t reg_target,
  input  cpu_pkg::word_t pc_plus4_id,
  output cpu_pkg::word_t pc
);

  cpu_pkg::word_t br_target;
  cpu_pkg::word_t jmp_target;
  cpu_pkg::word_t next_pc;

  // offsets are relative to the decode-stage pc+4
  assign br_target  = pc_plus4_id + {{16{imm16[15]}}, imm16};
  assign jmp_target = pc_plus4_id + {{6{jmp_imm26[25]}}, jmp_imm26};

  // only one of these is ever decoded at a time
  always_comb begin
    if (jmp_r)
      next_pc = reg_target;
    else if (jmp)
      next_pc = jmp_target;
    else if (branch)
      next_pc = br_target;
    else
      next_pc = pc + 32'd4;
  end

  // pc register, frozen while decode is stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= cpu_pkg::RESET_PC;
    end else if (!stall) begin
      pc <= next_pc;
    end
  end

endmodule

// File: control.sv
`timescale 1ns/10ps

module control (
  input  cpu_pkg::word_t inst,
  output logic           reg_wr,
  output logic           r_type,
  output logic           branch_z,
  output logic           branch_nz,
  output logic           jmp,
  output logic           jmp_r,
  output logic           link,
  output logic           imm_inst,
  output logic           imm_extend,
  output logic           mem_to_reg,
  output logic           mem_wr,
  output logic           reads_rs2,
  output cpu_pkg::func_t func_code
);

  logic [5:0] opcode;

  assign opcode = inst[31:26];

  always_comb begin
    // defaults give a no-op
    reg_wr     = 1'b0;
    r_type     = 1'b0;
    branch_z   = 1'b0;
    branch_nz  = 1'b0;
    jmp        = 1'b0;
    jmp_r      = 1'b0;
    link       = 1'b0;
    imm_inst   = 1'b0;
    imm_extend = 1'b0;
    mem_to_reg = 1'b0;
    mem_wr     = 1'b0;
    reads_rs2  = 1'b0;
    func_code  = cpu_pkg::FN_ADD;
    case (opcode)
      cpu_pkg::OP_RTYPE: begin
        // func passes straight to the alu
        reg_wr    = 1'b1;
        r_type    = 1'b1;
        reads_rs2 = 1'b1;
        func_code = inst[5:0];
      end
      cpu_pkg::OP_ADDI: begin
        reg_wr   = 1'b1;
        imm_inst = 1'b1;
      end
      cpu_pkg::OP_ANDI: begin
        reg_wr     = 1'b1;
        imm_inst   = 1'b1;
        imm_extend = 1'b1;
        func_code  = cpu_pkg::FN_AND;
      end
      cpu_pkg::OP_ORI: begin
        reg_wr     = 1'b1;
        imm_inst   = 1'b1;
        imm_extend = 1'b1;
        func_code  = cpu_pkg::FN_OR;
      end
      cpu_pkg::OP_LW: begin
        // address is rs1 + sign extended offset
        reg_wr     = 1'b1;
        imm_inst   = 1'b1;
        mem_to_reg = 1'b1;
      end
      cpu_pkg::OP_SW: begin
        // store data comes from the rs2 field
        imm_inst  = 1'b1;
        mem_wr    = 1'b1;
        reads_rs2 = 1'b1;
      end
      cpu_pkg::OP_BEQZ: branch_z  = 1'b1;
      cpu_pkg::OP_BNEZ: branch_nz = 1'b1;
      cpu_pkg::OP_J:    jmp       = 1'b1;
      cpu_pkg::OP_JAL: begin
        jmp    = 1'b1;
        link   = 1'b1;
        reg_wr = 1'b1;
      end
      cpu_pkg::OP_JR:   jmp_r     = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: reg_file_pipe.sv
`timescale 1ns/10ps

module reg_file_pipe (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  input  cpu_pkg::reg_idx_t rd_wb,
  input  logic              reg_wr,
  input  cpu_pkg::word_t    bus_w,
  output cpu_pkg::word_t    bus_a,
  output cpu_pkg::word_t    bus_b
);

  cpu_pkg::word_t regs [32];

  // one read port, r0 reads zero, same-cycle write passes through
  function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_idx_t idx,
                                               input cpu_pkg::word_t stored,
                                               input cpu_pkg::reg_idx_t wr_idx,
                                               input logic wr_en,
                                               input cpu_pkg::word_t wr_data);
    if (idx == '0)
      return '0;
    else if (wr_en && (wr_idx == idx))
      return wr_data;
    return stored;
  endfunction

  // write at the edge, r0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (reg_wr && (rd_wb != '0)) begin
      regs[rd_wb] <= bus_w;
    end
  end

  assign bus_a = read_port(rs1, regs[rs1], rd_wb, reg_wr, bus_w);
  assign bus_b = read_port(rs2, regs[rs2], rd_wb, reg_wr, bus_w);

endmodule

// File: hazard_forward.sv
`timescale 1ns/10ps

module hazard_forward (
  input  cpu_pkg::reg_idx_t id_rs1,
  input  cpu_pkg::reg_idx_t id_rs2,
  input  logic              id_reads_rs2,
  input  logic              id_uses_rs1_early,
  input  cpu_pkg::reg_idx_t ex_rd,
  input  logic              ex_reg_wr,
  input  logic              ex_mem_to_reg,
  input  cpu_pkg::reg_idx_t ex_rs1,
  input  cpu_pkg::reg_idx_t ex_rs2,
  input  cpu_pkg::reg_idx_t mem_rd,
  input  logic              mem_reg_wr,
  input  cpu_pkg::reg_idx_t wb_rd,
  input  logic              wb_reg_wr,
  output logic              stall,
  output logic [1:0]        fwd_a,
  output logic [1:0]        fwd_b
);

  logic ex_writes;
  logic mem_writes;
  logic wb_writes;
  logic load_use;
  logic branch_wait;

  // select 1 is the ex/mem result, 2 the write-back value, memory wins
  function automatic logic [1:0] fwd_sel(input cpu_pkg::reg_idx_t src,
                                         input logic m_wr,
                                         input cpu_pkg::reg_idx_t m_rd,
                                         input logic w_wr,
                                         input cpu_pkg::reg_idx_t w_rd);
    if (m_wr && (m_rd == src))
      return 2'd1;
    else if (w_wr && (w_rd == src))
      return 2'd2;
    return 2'd0;
  endfunction

  // r0 results are never worth waiting for
  assign ex_writes  = ex_reg_wr && (ex_rd != '0);
  assign mem_writes = mem_reg_wr && (mem_rd != '0);
  assign wb_writes  = wb_reg_wr && (wb_rd != '0);

  // load data only exists after memory, one bubble covers it
  // rs1 is checked even for jumps, a spare bubble is harmless
  assign load_use = ex_writes && ex_mem_to_reg &&
                    ((ex_rd == id_rs1) || (id_reads_rs2 && (ex_rd == id_rs2)));

  // branch and jr read rs1 in decode, wait until the producer hits write-back
  assign branch_wait = id_uses_rs1_early &&
                       ((ex_writes && (ex_rd == id_rs1)) ||
                        (mem_writes && (mem_rd == id_rs1)));

  assign stall = load_use || branch_wait;

  assign fwd_a = fwd_sel(ex_rs1, mem_writes, mem_rd, wb_writes, wb_rd);
  assign fwd_b = fwd_sel(ex_rs2, mem_writes, mem_rd, wb_writes, wb_rd);

endmodule

// File: execute.sv
`timescale 1ns/10ps

module execute (
  input  cpu_pkg::word_t bus_a,
  input  cpu_pkg::word_t bus_b,
  input  logic [15:0]    imm16,
  input  logic           imm_inst,
  input  logic           imm_extend,
  input  cpu_pkg::func_t alu_ctrl,
  output cpu_pkg::word_t alu_out
);

  cpu_pkg::word_t imm32;
  cpu_pkg::word_t op_b;

  // logical immediates zero extend, the rest sign extend
  assign imm32 = imm_extend ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
  assign op_b  = imm_inst ? imm32 : bus_b;

  always_comb begin
    case (alu_ctrl)
      cpu_pkg::FN_ADD: alu_out = bus_a + op_b;
      cpu_pkg::FN_SUB: alu_out = bus_a - op_b;
      cpu_pkg::FN_AND: alu_out = bus_a & op_b;
      cpu_pkg::FN_OR:  alu_out = bus_a | op_b;
      cpu_pkg::FN_XOR: alu_out = bus_a ^ op_b;
      // signed compare, result 1 or 0
      cpu_pkg::FN_SLT: alu_out = ($signed(bus_a) < $signed(op_b)) ? 32'd1 : 32'd0;
      // nop word has func 0, treat as add
      default:         alu_out = bus_a + op_b;
    endcase
  end

endmodule

// File: write_back.sv
`timescale 1ns/10ps

module write_back (
  input  cpu_pkg::word_t mem_data,
  input  cpu_pkg::word_t alu_out,
  input  cpu_pkg::word_t link_addr,
  input  logic           mem_to_reg,
  input  logic           link,
  output cpu_pkg::word_t wb_out
);

  // link first, then load data, else alu
  always_comb begin
    if (link)
      wb_out = link_addr;
    else if (mem_to_reg)
      wb_out = mem_data;
    else
      wb_out = alu_out;
  end

endmodule

// File: pipeline.sv
`timescale 1ns/10ps

module pipeline (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::word_t instruction,
  input  cpu_pkg::word_t mem_read_data,
  output cpu_pkg::word_t pc,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_write_data,
  output logic           mem_wr
);

  // fetch/decode register
  logic                if_id_valid;
  cpu_pkg::word_t      if_id_inst;
  cpu_pkg::word_t      if_id_pc_plus4;
  // decode stage
  cpu_pkg::word_t      id_inst;
  cpu_pkg::reg_idx_t   id_dest;
  cpu_pkg::word_t      bus_a;
  cpu_pkg::word_t      bus_b;
  logic                branch_taken;
  logic                stall;
  logic [1:0]          fwd_a;
  logic [1:0]          fwd_b;
  logic                ctl_reg_wr, ctl_r_type, ctl_branch_z, ctl_branch_nz;
  logic                ctl_jmp, ctl_jmp_r, ctl_link, ctl_imm_inst, ctl_imm_extend;
  logic                ctl_mem_to_reg, ctl_mem_wr, ctl_reads_rs2;
  cpu_pkg::func_t      ctl_func;
  // decode/execute register
  logic                id_ex_valid, id_ex_reg_wr, id_ex_mem_wr, id_ex_mem_to_reg;
  logic                id_ex_link, id_ex_imm_inst, id_ex_imm_extend;
  cpu_pkg::func_t      id_ex_func;
  cpu_pkg::word_t      id_ex_bus_a, id_ex_bus_b, id_ex_pc_plus4;
  cpu_pkg::reg_idx_t   id_ex_rs1, id_ex_rs2, id_ex_rd;
  logic [15:0]         id_ex_imm16;
  // execute stage
  cpu_pkg::word_t      ex_bus_a, ex_bus_b, ex_alu_out, ex_fwd_val;
  // execute/memory register
  logic                ex_mem_valid, ex_mem_reg_wr, ex_mem_mem_wr, ex_mem_mem_to_reg;
  logic                ex_mem_link;
  cpu_pkg::reg_idx_t   ex_mem_rd;
  cpu_pkg::word_t      ex_mem_alu, ex_mem_store, ex_mem_link_addr;
  // memory/write-back register
  logic                mem_wb_valid, mem_wb_reg_wr, mem_wb_mem_to_reg, mem_wb_link;
  cpu_pkg::reg_idx_t   mem_wb_rd;
  cpu_pkg::word_t      mem_wb_data, mem_wb_alu, mem_wb_link_addr, wb_out;

  // forwarding mux, 1 picks ex/mem, 2 picks write-back
  function automatic cpu_pkg::word_t fwd_mux(input logic [1:0] sel, input cpu_pkg::word_t reg_val,
                                             input cpu_pkg::word_t mem_val,
                                             input cpu_pkg::word_t wb_val);
    case (sel)
      2'd1:    return mem_val;
      2'd2:    return wb_val;
      default: return reg_val;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////////////////////////

  // jr takes bus_a directly, the branch stall makes it current
  inst_fetch u_fetch (.clk(clk), .rst_n(rst_n), .stall(stall), .branch(branch_taken),
                      .jmp(ctl_jmp), .jmp_r(ctl_jmp_r), .imm16(id_inst[15:0]),
                      .jmp_imm26(id_inst[25:0]), .reg_target(bus_a),
                      .pc_plus4_id(if_id_pc_plus4), .pc(pc));

  // held during a stall, the slot after a branch is never squashed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      if_id_valid    <= 1'b1;
      if_id_inst     <= instruction;
      if_id_pc_plus4 <= pc + 32'd4;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  // empty slot decodes as nop
  assign id_inst = if_id_valid ? if_id_inst : cpu_pkg::NOP_WORD;

  control u_ctrl (.inst(id_inst), .reg_wr(ctl_reg_wr), .r_type(ctl_r_type),
                  .branch_z(ctl_branch_z), .branch_nz(ctl_branch_nz), .jmp(ctl_jmp),
                  .jmp_r(ctl_jmp_r), .link(ctl_link), .imm_inst(ctl_imm_inst),
                  .imm_extend(ctl_imm_extend), .mem_to_reg(ctl_mem_to_reg),
                  .mem_wr(ctl_mem_wr), .reads_rs2(ctl_reads_rs2), .func_code(ctl_func));

  reg_file_pipe u_regs (.clk(clk), .rst_n(rst_n), .rs1(id_inst[25:21]), .rs2(id_inst[20:16]),
                        .rd_wb(mem_wb_rd), .reg_wr(mem_wb_valid & mem_wb_reg_wr),
                        .bus_w(wb_out), .bus_a(bus_a), .bus_b(bus_b));

  hazard_forward u_hazard (.id_rs1(id_inst[25:21]), .id_rs2(id_inst[20:16]),
                           .id_reads_rs2(ctl_reads_rs2),
                           .id_uses_rs1_early(ctl_branch_z | ctl_branch_nz | ctl_jmp_r),
                           .ex_rd(id_ex_rd), .ex_reg_wr(id_ex_valid & id_ex_reg_wr),
                           .ex_mem_to_reg(id_ex_mem_to_reg), .ex_rs1(id_ex_rs1),
                           .ex_rs2(id_ex_rs2), .mem_rd(ex_mem_rd),
                           .mem_reg_wr(ex_mem_valid & ex_mem_reg_wr), .wb_rd(mem_wb_rd),
                           .wb_reg_wr(mem_wb_valid & mem_wb_reg_wr), .stall(stall),
                           .fwd_a(fwd_a), .fwd_b(fwd_b));

  // zero test on rs1 decides beqz and bnez
  assign branch_taken = (ctl_branch_z & (bus_a == '0)) | (ctl_branch_nz & (bus_a != '0));

  // destination is rd for r-type, rs2 field for immediates, r31 for jal
  assign id_dest = ctl_link   ? cpu_pkg::LINK_REG :
                   ctl_r_type ? id_inst[15:11] : id_inst[20:16];

  // a stall sends a bubble, write enables dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex_valid  <= 1'b0;
      id_ex_reg_wr <= 1'b0;
      id_ex_mem_wr <= 1'b0;
    end else begin
      id_ex_valid      <= if_id_valid & ~stall;
      id_ex_reg_wr     <= ctl_reg_wr & ~stall;
      id_ex_mem_wr     <= ctl_mem_wr & ~stall;
      id_ex_mem_to_reg <= ctl_mem_to_reg;
      id_ex_link       <= ctl_link;
      id_ex_imm_inst   <= ctl_imm_inst;
      id_ex_imm_extend <= ctl_imm_extend;
      id_ex_func       <= ctl_func;
      id_ex_bus_a      <= bus_a;
      id_ex_bus_b      <= bus_b;
      id_ex_rs1        <= id_inst[25:21];
      id_ex_rs2        <= id_inst[20:16];
      id_ex_rd         <= id_dest;
      id_ex_imm16      <= id_inst[15:0];
      id_ex_pc_plus4   <= if_id_pc_plus4;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // execute, memory, write-back
  //////////////////////////////////////////////////////////////////////

  // a jal in memory forwards its link address, not the alu result
  assign ex_fwd_val = ex_mem_link ? ex_mem_link_addr : ex_mem_alu;
  assign ex_bus_a   = fwd_mux(fwd_a, id_ex_bus_a, ex_fwd_val, wb_out);
  assign ex_bus_b   = fwd_mux(fwd_b, id_ex_bus_b, ex_fwd_val, wb_out);

  execute u_exec (.bus_a(ex_bus_a), .bus_b(ex_bus_b), .imm16(id_ex_imm16),
                  .imm_inst(id_ex_imm_inst), .imm_extend(id_ex_imm_extend),
                  .alu_ctrl(id_ex_func), .alu_out(ex_alu_out));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem_valid  <= 1'b0;
      ex_mem_reg_wr <= 1'b0;
      ex_mem_mem_wr <= 1'b0;
    end else begin
      ex_mem_valid      <= id_ex_valid;
      ex_mem_reg_wr     <= id_ex_reg_wr;
      ex_mem_mem_wr     <= id_ex_mem_wr;
      ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      ex_mem_link       <= id_ex_link;
      ex_mem_rd         <= id_ex_rd;
      ex_mem_alu        <= ex_alu_out;
      ex_mem_store      <= ex_bus_b;
      // return past the delay slot
      ex_mem_link_addr  <= id_ex_pc_plus4 + 32'd4;
    end
  end

  // data memory answers in the same cycle
  assign mem_addr       = ex_mem_alu;
  assign mem_write_data = ex_mem_store;
  assign mem_wr         = ex_mem_valid & ex_mem_mem_wr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb_valid  <= 1'b0;
      mem_wb_reg_wr <= 1'b0;
    end else begin
      mem_wb_valid      <= ex_mem_valid;
      mem_wb_reg_wr     <= ex_mem_reg_wr;
      mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      mem_wb_link       <= ex_mem_link;
      mem_wb_rd         <= ex_mem_rd;
      mem_wb_data       <= mem_read_data;
      mem_wb_alu        <= ex_mem_alu;
      mem_wb_link_addr  <= ex_mem_link_addr;
    end
  end

  write_back u_wb (.mem_data(mem_wb_data), .alu_out(mem_wb_alu), .link_addr(mem_wb_link_addr),
                   .mem_to_reg(mem_wb_mem_to_reg), .link(mem_wb_link), .wb_out(wb_out));

endmodule

// File: pipeline_asserts.sv
`timescale 1ns/10ps

module pipeline_asserts (
  input logic           clk,
  input logic           rst_n,
  input cpu_pkg::word_t pc,
  input logic           mem_wr,
  input logic           stall
);

  // ex/mem register is clear one edge after reset
  reset_quiet: assert property (@(posedge clk) !rst_n |=> !mem_wr)
    else $error("mem_wr high in the cycle after reset");

  // all targets are word offsets
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // stall freezes fetch for that cycle
  stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(pc))
    else $error("pc moved during a stall");

endmodule

bind pipeline pipeline_asserts u_asserts (
  .clk(clk),
  .rst_n(rst_n),
  .pc(pc),
  .mem_wr(mem_wr),
  .stall(stall)
);

// File: tb_pipeline.sv
`timescale 1ns/10ps

module tb_pipeline;

  localparam int PERIOD      = 40;
  localparam int TIMEOUT     = 200;
  localparam int IDLE_CYCLES = 12;
  localparam logic [31:0] SEED = 32'd71040;
  localparam int N_TESTS = 16;
  // program shapes
  localparam int K_RTYPE   = 0;
  localparam int K_IMM     = 1;
  localparam int K_LOADUSE = 2;
  localparam int K_BRANCH  = 3;
  localparam int K_JUMP    = 4;
  localparam int K_JAL     = 5;
  localparam int K_JR      = 6;
  localparam int K_R0      = 7;
  // operand and result byte addresses in data memory
  localparam int ADDR_A = 'h40;
  localparam int ADDR_B = 'h44;
  localparam int ADDR_R = 'h80;

  logic           clk = 1'b0;
  logic           rst_n = 1'b0;
  logic           fill_dmem = 1'b0;
  logic           mem_wr;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t instruction;
  cpu_pkg::word_t mem_addr;
  cpu_pkg::word_t mem_write_data;
  cpu_pkg::word_t mem_read_data;

  cpu_pkg::word_t imem [64];
  cpu_pkg::word_t dmem [64];
  cpu_pkg::word_t st_addr [$];
  cpu_pkg::word_t st_data [$];
  cpu_pkg::word_t prog [$];
  cpu_pkg::word_t exp_addr [$];
  cpu_pkg::word_t exp_data [$];
  cpu_pkg::word_t op_a;
  cpu_pkg::word_t op_b;
  logic [31:0]    lfsr = SEED;

  // one row per test
  // code holds the func for r-type rows and the opcode for the rest
  string      test_name [N_TESTS] = '{"add", "sub", "and", "or", "xor", "slt", "addi", "andi",
                                      "ori", "load_use", "beqz", "bnez", "j", "jal", "jr", "r0"};
  int         test_kind [N_TESTS] = '{K_RTYPE, K_RTYPE, K_RTYPE, K_RTYPE, K_RTYPE, K_RTYPE,
                                      K_IMM, K_IMM, K_IMM, K_LOADUSE, K_BRANCH, K_BRANCH,
                                      K_JUMP, K_JAL, K_JR, K_R0};
  logic [5:0] test_code [N_TESTS] = '{cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND,
                                      cpu_pkg::FN_OR, cpu_pkg::FN_XOR, cpu_pkg::FN_SLT,
                                      cpu_pkg::OP_ADDI, cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI,
                                      cpu_pkg::OP_LW, cpu_pkg::OP_BEQZ, cpu_pkg::OP_BNEZ,
                                      cpu_pkg::OP_J, cpu_pkg::OP_JAL, cpu_pkg::OP_JR,
                                      cpu_pkg::FN_ADD};
  // bit 15 set so sign and zero extension differ
  int         test_imm  [N_TESTS] = '{0, 0, 0, 0, 0, 0, 'h8005, 'h8ff0, 'h9001,
                                      0, 0, 0, 0, 0, 0, 0};

  pipeline dut0 (
    .clk(clk),
    .rst_n(rst_n),
    .instruction(instruction),
    .mem_read_data(mem_read_data),
    .pc(pc),
    .mem_addr(mem_addr),
    .mem_write_data(mem_write_data),
    .mem_wr(mem_wr)
  );

  always #(PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // memory models
  //////////////////////////////////////////////////////////////////////

  // single-cycle memories indexed by byte address bits 7:2
  assign instruction   = imem[pc[7:2]];
  assign mem_read_data = dmem[mem_addr[7:2]];

  // operand fill during reset and the store port otherwise
  always @(posedge clk) begin
    if (fill_dmem) begin
      for (int i = 0; i < 64; i++)
        dmem[i] <= {16'hd0d0, 16'(i * 4)};
      dmem[ADDR_A / 4] <= op_a;
      dmem[ADDR_B / 4] <= op_b;
    end else if (mem_wr === 1'b1) begin
      dmem[mem_addr[7:2]] <= mem_write_data;
      st_addr.push_back(mem_addr);
      st_data.push_back(mem_write_data);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // encoders, models, random source
  //////////////////////////////////////////////////////////////////////

  function automatic cpu_pkg::word_t enc_r(input logic [5:0] fn, input int rd, input int rs1,
                                           input int rs2);
    return {cpu_pkg::OP_RTYPE, 5'(rs1), 5'(rs2), 5'(rd), 5'd0, fn};
  endfunction

  // rt sits in the rs2 field and names the destination or store data
  function automatic cpu_pkg::word_t enc_i(input logic [5:0] op, input int rt, input int rs1,
                                           input int imm);
    return {op, 5'(rs1), 5'(rt), 16'(imm)};
  endfunction

  function automatic cpu_pkg::word_t enc_j(input logic [5:0] op, input int offset);
    return {op, 26'(offset)};
  endfunction

  function automatic cpu_pkg::word_t alu_model(input logic [5:0] fn, input cpu_pkg::word_t a,
                                               input cpu_pkg::word_t b);
    case (fn)
      cpu_pkg::FN_SUB: return a - b;
      cpu_pkg::FN_AND: return a & b;
      cpu_pkg::FN_OR:  return a | b;
      cpu_pkg::FN_XOR: return a ^ b;
      cpu_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:         return a + b;
    endcase
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output cpu_pkg::word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input cpu_pkg::word_t expected,
                             input cpu_pkg::word_t actual);
    if (actual !== expected)
      abort_run($sformatf("ERROR %s expected %h actual %h", what, expected, actual));
  endtask

  task automatic expect_store(input int addr, input cpu_pkg::word_t data);
    exp_addr.push_back(32'(addr));
    exp_data.push_back(data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // programs
  //////////////////////////////////////////////////////////////////////

  task automatic build_program(input int t);
    cpu_pkg::word_t r3;
    cpu_pkg::word_t imm32;
    logic [15:0]    imm16;
    logic [5:0]     fn;
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    draw_word(op_a);
    draw_word(op_b);
    imm16 = 16'(test_imm[t]);
    // r1 and r2 hold the operands
    prog.push_back(enc_i(cpu_pkg::OP_LW, 1, 0, ADDR_A));
    prog.push_back(enc_i(cpu_pkg::OP_LW, 2, 0, ADDR_B));
    case (test_kind[t])
      K_RTYPE: begin
        // second op takes r3 from the memory stage and the stores take theirs from write-back
        r3 = alu_model(test_code[t], op_a, op_b);
        prog.push_back(enc_r(test_code[t], 3, 1, 2));
        prog.push_back(enc_r(test_code[t], 4, 3, 1));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 3, 0, ADDR_R));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 4, 0, ADDR_R + 4));
        expect_store(ADDR_R, r3);
        expect_store(ADDR_R + 4, alu_model(test_code[t], r3, op_a));
      end
      K_IMM: begin
        if (test_code[t] == cpu_pkg::OP_ADDI) begin
          imm32 = {{16{imm16[15]}}, imm16};
          fn = cpu_pkg::FN_ADD;
        end else begin
          imm32 = {16'h0000, imm16};
          fn = (test_code[t] == cpu_pkg::OP_ANDI) ? cpu_pkg::FN_AND : cpu_pkg::FN_OR;
        end
        prog.push_back(enc_i(test_code[t], 3, 1, test_imm[t]));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 3, 0, ADDR_R));
        expect_store(ADDR_R, alu_model(fn, op_a, imm32));
      end
      K_LOADUSE: begin
        prog.push_back(enc_i(cpu_pkg::OP_LW, 5, 0, ADDR_A));
        prog.push_back(enc_r(cpu_pkg::FN_ADD, 6, 5, 2));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 6, 0, ADDR_R));
        expect_store(ADDR_R, op_a + op_b);
      end
      K_BRANCH: begin
        // r7 is zero and is still in flight when the branch decodes
        prog.push_back(enc_r(cpu_pkg::FN_SUB, 7, 1, 1));
        prog.push_back(enc_i(test_code[t], 0, 7, 8));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 1, 0, ADDR_R));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 2, 0, ADDR_R + 4));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 2, 0, ADDR_R + 8));
        expect_store(ADDR_R, op_a);
        if (test_code[t] == cpu_pkg::OP_BNEZ)
          expect_store(ADDR_R + 4, op_b);
        expect_store(ADDR_R + 8, op_b);
      end
      K_JUMP: begin
        prog.push_back(enc_j(cpu_pkg::OP_J, 8));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 1, 0, ADDR_R));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 2, 0, ADDR_R + 4));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 2, 0, ADDR_R + 8));
        expect_store(ADDR_R, op_a);
        expect_store(ADDR_R + 8, op_b);
      end
      K_JAL: begin
        // return address skips the delay slot
        expect_store(ADDR_R, op_a);
        expect_store(ADDR_R + 4, 32'(4 * prog.size() + 8));
        prog.push_back(enc_j(cpu_pkg::OP_JAL, 4));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 1, 0, ADDR_R));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 31, 0, ADDR_R + 4));
      end
      K_JR: begin
        // target is word 6 holding the last store
        prog.push_back(enc_i(cpu_pkg::OP_ADDI, 9, 0, 'h18));
        prog.push_back(enc_i(cpu_pkg::OP_JR, 0, 9, 0));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 1, 0, ADDR_R));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 2, 0, ADDR_R + 4));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 2, 0, ADDR_R + 8));
        expect_store(ADDR_R, op_a);
        expect_store(ADDR_R + 8, op_b);
      end
      default: begin
        prog.push_back(enc_r(cpu_pkg::FN_ADD, 0, 1, 2));
        prog.push_back(enc_i(cpu_pkg::OP_SW, 0, 0, ADDR_R));
        expect_store(ADDR_R, 32'd0);
      end
    endcase
    // halt by jumping to itself
    prog.push_back(enc_j(cpu_pkg::OP_J, -4));
  endtask

  task automatic run_program(input int t);
    int cycles;
    int base;
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    // pipeline registers now cleared so the old program is gone
    fill_dmem <= 1'b1;
    @(negedge clk);
    for (int i = 0; i < 64; i++)
      imem[i] = (i < prog.size()) ? prog[i] : cpu_pkg::NOP_WORD;
    base = st_addr.size();
    @(posedge clk);
    fill_dmem <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value({test_name[t], " first pc"}, 32'h0000_0000, pc);
    check_value({test_name[t], " stores in reset"}, 32'd0, 32'(st_addr.size() - base));
    cycles = 0;
    while (st_addr.size() - base < exp_addr.size()) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        abort_run($sformatf("%s timed out, expected stores missing after %0d cycles",
                            test_name[t], TIMEOUT));
    end
    // skipped stores would land in this window
    repeat (IDLE_CYCLES) @(negedge clk);
    check_value({test_name[t], " store count"}, 32'(exp_addr.size()),
                32'(st_addr.size() - base));
    foreach (exp_addr[k]) begin
      check_value($sformatf("%s store %0d address", test_name[t], k), exp_addr[k],
                  st_addr[base + k]);
      check_value($sformatf("%s store %0d data", test_name[t], k), exp_data[k],
                  st_data[base + k]);
    end
  endtask

  initial begin
    for (int i = 0; i < 64; i++)
      imem[i] = cpu_pkg::NOP_WORD;
    for (int t = 0; t < N_TESTS; t++) begin
      build_program(t);
      run_program(t);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: files.f
cpu_pkg.sv
inst_fetch.sv
control.sv
reg_file_pipe.sv
hazard_forward.sv
execute.sv
write_back.sv
pipeline.sv
pipeline_asserts.sv
tb_pipeline.sv

// File: Makefile
TOP := tb_pipeline

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | awk '{ print } /TEST RESULT: PASS/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
